/* vcache_profiler_top.f */
+incdir+logic
logic/vcache_op_pkg.sv
logic/vcache_stat_pkg.sv
logic/vcache_op_decode.sv
logic/vcache_event_gen.sv
logic/vcache_stat_bank.sv
logic/vcache_profiler_top.sv
bench/vcache_profiler_asserts.sv
bench/vcache_profiler_tb.sv

/* Bender.yml */
package:
  name: vcache_profiler

export_include_dirs:
  - logic

sources:
  - logic/vcache_op_pkg.sv
  - logic/vcache_stat_pkg.sv
  - logic/vcache_op_decode.sv
  - logic/vcache_event_gen.sv
  - logic/vcache_stat_bank.sv
  - logic/vcache_profiler_top.sv
  - target: test
    files:
      - bench/vcache_profiler_asserts.sv
      - bench/vcache_profiler_tb.sv

/* bench/vcache_profiler_tb.sv */
`include "vcache_cfg.svh"

module vcache_profiler_tb
  import vcache_op_pkg::*, vcache_stat_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES   = 5;
  localparam int NUM_CYCLES     = 2000;
  localparam int MID_RESET_AT   = 1000;
  localparam int PRINT_PERIOD   = 50;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 100;

  logic             clk_i                = 1'b0;
  logic             reset_i              = 1'b1;
  logic             v_i                  = 1'b0;
  logic             yumi_i               = 1'b0;
  logic             miss_v_i             = 1'b0;
  vcache_opcode_t   opcode_i             = '0;
  logic             dma_v_i              = 1'b0;
  logic             dma_yumi_i           = 1'b0;
  logic             dma_write_not_read_i = 1'b0;
  logic             trace_en_i           = 1'b0;
  logic             print_stat_v_i       = 1'b0;
  vcache_tag_t      print_stat_tag_i     = '0;
  vcache_stat_sel_e stat_sel_i           = STAT_LD;
  vcache_ctr_t      stat_data_o;
  vcache_tag_t      stat_tag_o;
  logic             trace_v_o;
  vcache_trace_e    trace_code_o;

  // reference model
  vcache_ctr_t      cnt  [`VCACHE_NUM_STATS];
  vcache_ctr_t      snap [`VCACHE_NUM_STATS];
  vcache_tag_t      snap_tag;
  logic             exp_trace_v;
  vcache_trace_e    exp_trace_code;
  logic             check_en    = 1'b0;
  int               seed        = 84946;
  int               cycle_count = 0;

  vcache_profiler_top i_dut (.*);

  always #5 clk_i = ~clk_i;

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_ctr(input vcache_stat_sel_e sel, input vcache_ctr_t exp, act);
    if (act !== exp) begin
      $display("ERR stat_data_o sel %h exp %h act %h", sel, exp, act);
      abort_run();
    end
  endtask

  task automatic check_tag(input vcache_tag_t exp, act);
    if (act !== exp) begin
      $display("ERR stat_tag_o exp %h act %h", exp, act);
      abort_run();
    end
  endtask

  task automatic check_trace(input logic exp_v, act_v,
                             input vcache_trace_e exp_code, act_code);
    if (act_v !== exp_v || act_code !== exp_code) begin
      $display("ERR trace_v_o exp %h act %h trace_code_o exp %h act %h",
               exp_v, act_v, exp_code, act_code);
      abort_run();
    end
  endtask

  // steps with the DUT, on the inputs of the cycle that just ended
  always @(posedge clk_i) begin : model
    vcache_op_class_e cls;
    logic             acc;
    logic             miss_ld;
    logic             miss_st;
    case (opcode_i)
      LD, LDU, LW, LWU, LH, LHU, LB, LBU: cls = CLASS_LD;
      SD, SW, SH, SB:                     cls = CLASS_ST;
      TAGST, TAGFL:                       cls = CLASS_TAG;
      AFL, AINV:                          cls = CLASS_FLUSH;
      AMOSWAP, AMOOR:                     cls = CLASS_ATOMIC;
      default:                            cls = CLASS_NONE;
    endcase
    acc     = v_i & yumi_i;
    miss_ld = acc & miss_v_i & (cls == CLASS_LD);
    miss_st = acc & miss_v_i & (cls == CLASS_ST);
    if (reset_i) begin
      cnt            = '{default: '0};
      snap           = '{default: '0};
      snap_tag       = '0;
      exp_trace_v    = 1'b0;
      exp_trace_code = TR_IDLE;
    end else begin
      // snapshot sees the counts from before this cycle
      if (print_stat_v_i) begin
        snap     = cnt;
        snap_tag = print_stat_tag_i;
      end
      if (acc && cls == CLASS_LD) cnt[STAT_LD] += 1;
      if (acc && cls == CLASS_ST) cnt[STAT_ST] += 1;
      if (acc && cls == CLASS_TAG) cnt[STAT_TAG] += 1;
      if (acc && cls == CLASS_FLUSH) cnt[STAT_FLUSH] += 1;
      if (acc && cls == CLASS_ATOMIC) cnt[STAT_ATOMIC] += 1;
      if (acc && (opcode_i == LB || opcode_i == LH || opcode_i == LW)) cnt[STAT_SIGEXT] += 1;
      if (miss_ld) cnt[STAT_LD_MISS] += 1;
      if (miss_st) cnt[STAT_ST_MISS] += 1;
      if (miss_v_i) cnt[STAT_MISS_CYCLES] += 1;
      if (!acc && !miss_v_i) cnt[STAT_IDLE_CYCLES] += 1;
      if (dma_v_i && dma_yumi_i && !dma_write_not_read_i) cnt[STAT_DMA_READ] += 1;
      if (dma_v_i && dma_yumi_i && dma_write_not_read_i) cnt[STAT_DMA_WRITE] += 1;
      exp_trace_v = trace_en_i;
      if (miss_ld) exp_trace_code = TR_MISS_LD;
      else if (miss_st) exp_trace_code = TR_MISS_ST;
      else if (miss_v_i) exp_trace_code = TR_MISS;
      else if (!acc) exp_trace_code = TR_IDLE;
      else if (cls == CLASS_LD) exp_trace_code = TR_LD;
      else if (cls == CLASS_ST) exp_trace_code = TR_ST;
      else if (cls == CLASS_TAG) exp_trace_code = TR_TAG;
      else if (cls == CLASS_FLUSH) exp_trace_code = TR_FLUSH;
      else if (cls == CLASS_ATOMIC) exp_trace_code = TR_ATOMIC;
      else exp_trace_code = TR_OTHER;
    end
  end

  // outputs settle well before the falling edge
  always @(negedge clk_i) begin
    if (check_en) begin
      check_trace(exp_trace_v, trace_v_o, exp_trace_code, trace_code_o);
      check_tag(snap_tag, stat_tag_o);
      if (stat_sel_i < `VCACHE_NUM_STATS) begin
        check_ctr(stat_sel_i, snap[stat_sel_i], stat_data_o);
      end else begin
        check_ctr(stat_sel_i, '0, stat_data_o);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial begin
    logic [31:0] r;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i  <= 1'b0;
    check_en <= 1'b1;
    for (int c = 0; c < NUM_CYCLES; c++) begin
      r = $random(seed);
      v_i                  <= r[0];
      yumi_i               <= r[1] | r[13];
      miss_v_i             <= r[2] & r[3];
      opcode_i             <= r[8:4];
      dma_v_i              <= r[9];
      dma_yumi_i           <= r[10];
      dma_write_not_read_i <= r[11];
      trace_en_i           <= r[12];
      print_stat_v_i       <= (c % PRINT_PERIOD == PRINT_PERIOD - 1);
      print_stat_tag_i     <= vcache_tag_t'($random(seed));
      // walks every entry plus the four empty selects
      stat_sel_i           <= vcache_stat_sel_e'(c[3:0]);
      if (c == MID_RESET_AT) reset_i <= 1'b1;
      if (c == MID_RESET_AT + 3) reset_i <= 1'b0;
      @(posedge clk_i);
    end
    @(posedge clk_i);
    if (i_dut.i_asserts.fail_count != 0) begin
      $display("%0d bound assertion failures", i_dut.i_asserts.fail_count);
      abort_run();
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

/* bench/vcache_profiler_asserts.sv */
module vcache_profiler_asserts
  import vcache_stat_pkg::*;
(
  input logic        clk_i,
  input logic        reset_i,
  input logic        trace_en_i,
  input logic        trace_v_o,
  input logic        print_stat_v_i,
  input vcache_tag_t stat_tag_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  trace_reset_a : assert property (@(posedge clk_i) reset_i |=> !trace_v_o)
    else begin
      fail_count++;
      $error("trace_v_o high in the cycle after reset");
    end

  trace_follow_a : assert property (
    @(posedge clk_i) !reset_i |=> (trace_v_o == $past(trace_en_i)))
    else begin
      fail_count++;
      $error("trace_v_o does not follow trace_en_i");
    end

  // tag only moves on a print or a reset
  tag_hold_a : assert property (@(posedge clk_i) disable iff (reset_i)
    !$stable(stat_tag_o) |-> ($past(print_stat_v_i) || $past(reset_i)))
    else begin
      fail_count++;
      $error("stat_tag_o changed without a print strobe");
    end

endmodule

bind vcache_profiler_top vcache_profiler_asserts i_asserts (.*);

/* logic/vcache_profiler_top.sv */
module vcache_profiler_top
  import vcache_op_pkg::*, vcache_stat_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             v_i,
  input  logic             yumi_i,
  input  logic             miss_v_i,
  input  vcache_opcode_t   opcode_i,
  input  logic             dma_v_i,
  input  logic             dma_yumi_i,
  input  logic             dma_write_not_read_i,
  input  logic             trace_en_i,
  input  logic             print_stat_v_i,
  input  vcache_tag_t      print_stat_tag_i,
  input  vcache_stat_sel_e stat_sel_i,
  output vcache_ctr_t      stat_data_o,
  output vcache_tag_t      stat_tag_o,
  output logic             trace_v_o,
  output vcache_trace_e    trace_code_o
);

  vcache_op_class_e op_class;
  logic             is_sigext;
  vcache_inc_t      inc;

  vcache_op_decode i_op_decode (
    .opcode_i    (opcode_i),
    .op_class_o  (op_class),
    .is_sigext_o (is_sigext)
  );

  vcache_event_gen i_event_gen (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .v_i                  (v_i),
    .yumi_i               (yumi_i),
    .miss_v_i             (miss_v_i),
    .dma_v_i              (dma_v_i),
    .dma_yumi_i           (dma_yumi_i),
    .dma_write_not_read_i (dma_write_not_read_i),
    .trace_en_i           (trace_en_i),
    .op_class_i           (op_class),
    .is_sigext_i          (is_sigext),
    .inc_o                (inc),
    .trace_v_o            (trace_v_o),
    .trace_code_o         (trace_code_o)
  );

  vcache_stat_bank i_stat_bank (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .inc_i            (inc),
    .print_stat_v_i   (print_stat_v_i),
    .print_stat_tag_i (print_stat_tag_i),
    .stat_sel_i       (stat_sel_i),
    .stat_data_o      (stat_data_o),
    .stat_tag_o       (stat_tag_o)
  );

endmodule

/* logic/vcache_stat_bank.sv */
`include "vcache_cfg.svh"

module vcache_stat_bank
  import vcache_stat_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  vcache_inc_t      inc_i,
  input  logic             print_stat_v_i,
  input  vcache_tag_t      print_stat_tag_i,
  input  vcache_stat_sel_e stat_sel_i,
  output vcache_ctr_t      stat_data_o,
  output vcache_tag_t      stat_tag_o
);

  vcache_ctr_t ctr_q  [`VCACHE_NUM_STATS];
  vcache_ctr_t snap_q [`VCACHE_NUM_STATS];
  vcache_tag_t tag_q;

  // live counters, wrap on overflow
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `VCACHE_NUM_STATS; i++) begin
        ctr_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `VCACHE_NUM_STATS; i++) begin
        if (inc_i[i]) begin
          ctr_q[i] <= ctr_q[i] + vcache_ctr_t'(1);
        end
      end
    end
  end

  // snapshot takes the counts from before this cycle's events
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `VCACHE_NUM_STATS; i++) begin
        snap_q[i] <= '0;
      end
      tag_q <= '0;
    end else if (print_stat_v_i) begin
      snap_q <= ctr_q;
      tag_q  <= print_stat_tag_i;
    end
  end

  // out-of-range select reads zero
  assign stat_data_o = (stat_sel_i < `VCACHE_NUM_STATS) ? snap_q[stat_sel_i] : '0;
  assign stat_tag_o  = tag_q;

endmodule

/* logic/vcache_event_gen.sv */
module vcache_event_gen
  import vcache_op_pkg::*, vcache_stat_pkg::*;
(
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             v_i,
  input  logic             yumi_i,
  input  logic             miss_v_i,
  input  logic             dma_v_i,
  input  logic             dma_yumi_i,
  input  logic             dma_write_not_read_i,
  input  logic             trace_en_i,
  input  vcache_op_class_e op_class_i,
  input  logic             is_sigext_i,
  output vcache_inc_t      inc_o,
  output logic             trace_v_o,
  output vcache_trace_e    trace_code_o
);

  logic          accept;
  logic          dma_accept;
  logic          ld_miss;
  logic          st_miss;
  vcache_trace_e trace_next;

  assign accept     = v_i & yumi_i;
  assign dma_accept = dma_v_i & dma_yumi_i;

  // a miss retires when its response is taken while the handler is still busy
  assign ld_miss = accept & miss_v_i & (op_class_i == CLASS_LD);
  assign st_miss = accept & miss_v_i & (op_class_i == CLASS_ST);

  always_comb begin
    inc_o                   = '0;
    inc_o[STAT_LD]          = accept & (op_class_i == CLASS_LD);
    inc_o[STAT_ST]          = accept & (op_class_i == CLASS_ST);
    inc_o[STAT_SIGEXT]      = accept & is_sigext_i;
    inc_o[STAT_TAG]         = accept & (op_class_i == CLASS_TAG);
    inc_o[STAT_FLUSH]       = accept & (op_class_i == CLASS_FLUSH);
    inc_o[STAT_ATOMIC]      = accept & (op_class_i == CLASS_ATOMIC);
    inc_o[STAT_LD_MISS]     = ld_miss;
    inc_o[STAT_ST_MISS]     = st_miss;
    inc_o[STAT_MISS_CYCLES] = miss_v_i;
    inc_o[STAT_IDLE_CYCLES] = ~accept & ~miss_v_i;
    inc_o[STAT_DMA_READ]    = dma_accept & ~dma_write_not_read_i;
    inc_o[STAT_DMA_WRITE]   = dma_accept & dma_write_not_read_i;
  end

  // miss events first, then the retiring op class
  always_comb begin
    if (ld_miss) begin
      trace_next = TR_MISS_LD;
    end else if (st_miss) begin
      trace_next = TR_MISS_ST;
    end else if (miss_v_i) begin
      trace_next = TR_MISS;
    end else if (accept) begin
      case (op_class_i)
        CLASS_LD:     trace_next = TR_LD;
        CLASS_ST:     trace_next = TR_ST;
        CLASS_TAG:    trace_next = TR_TAG;
        CLASS_FLUSH:  trace_next = TR_FLUSH;
        CLASS_ATOMIC: trace_next = TR_ATOMIC;
        default:      trace_next = TR_OTHER;
      endcase
    end else begin
      trace_next = TR_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      trace_v_o    <= 1'b0;
      trace_code_o <= TR_IDLE;
    end else begin
      trace_v_o    <= trace_en_i;
      trace_code_o <= trace_next;
    end
  end

endmodule

/* logic/vcache_op_decode.sv */
module vcache_op_decode
  import vcache_op_pkg::*;
(
  input  vcache_opcode_t   opcode_i,
  output vcache_op_class_e op_class_o,
  output logic             is_sigext_o
);

  always_comb begin
    case (opcode_i)
      LD, LDU, LW, LWU, LH, LHU, LB, LBU: begin
        op_class_o = CLASS_LD;
      end
      SD, SW, SH, SB: begin
        op_class_o = CLASS_ST;
      end
      TAGST, TAGFL: begin
        op_class_o = CLASS_TAG;
      end
      AFL, AINV: begin
        op_class_o = CLASS_FLUSH;
      end
      AMOSWAP, AMOOR: begin
        op_class_o = CLASS_ATOMIC;
      end
      default: begin
        op_class_o = CLASS_NONE;
      end
    endcase
  end

  // signed loads narrower than the data word
  always_comb begin
    case (opcode_i)
      LB, LH, LW: begin
        is_sigext_o = 1'b1;
      end
      default: begin
        is_sigext_o = 1'b0;
      end
    endcase
  end

endmodule

/* logic/vcache_stat_pkg.sv */
`include "vcache_cfg.svh"

package vcache_stat_pkg;

  typedef logic [`VCACHE_CTR_WIDTH-1:0] vcache_ctr_t;
  typedef logic [`VCACHE_TAG_WIDTH-1:0] vcache_tag_t;
  typedef logic [`VCACHE_NUM_STATS-1:0] vcache_inc_t;

  // counter index, also the bit position in vcache_inc_t
  typedef enum logic [`VCACHE_STAT_SEL_WIDTH-1:0] {
    STAT_LD, STAT_ST, STAT_SIGEXT, STAT_TAG, STAT_FLUSH, STAT_ATOMIC,
    STAT_LD_MISS, STAT_ST_MISS, STAT_MISS_CYCLES, STAT_IDLE_CYCLES,
    STAT_DMA_READ, STAT_DMA_WRITE
  } vcache_stat_sel_e;

  typedef enum logic [3:0] {
    TR_IDLE    = 4'd0,
    TR_MISS_LD = 4'd1,
    TR_MISS_ST = 4'd2,
    TR_MISS    = 4'd3,
    TR_LD      = 4'd4,
    TR_ST      = 4'd5,
    TR_TAG     = 4'd6,
    TR_FLUSH   = 4'd7,
    TR_ATOMIC  = 4'd8,
    TR_OTHER   = 4'd9
  } vcache_trace_e;

endpackage

/* logic/vcache_op_pkg.sv */
`include "vcache_cfg.svh"

package vcache_op_pkg;

  typedef logic [`VCACHE_OPCODE_WIDTH-1:0] vcache_opcode_t;

  // gaps in the opcode map are unused codes
  typedef enum logic [`VCACHE_OPCODE_WIDTH-1:0] {
    LB      = 5'b00000,
    LH      = 5'b00001,
    LW      = 5'b00010,
    LD      = 5'b00011,
    LBU     = 5'b00100,
    LHU     = 5'b00101,
    LWU     = 5'b00110,
    LDU     = 5'b00111,
    SB      = 5'b01000,
    SH      = 5'b01001,
    SW      = 5'b01010,
    SD      = 5'b01011,
    AMOSWAP = 5'b01100,
    AMOOR   = 5'b01101,
    TAGST   = 5'b10000,
    TAGFL   = 5'b10001,
    AFL     = 5'b11000,
    AINV    = 5'b11010
  } vcache_op_e;

  typedef enum logic [2:0] {
    CLASS_NONE   = 3'd0,
    CLASS_LD     = 3'd1,
    CLASS_ST     = 3'd2,
    CLASS_TAG    = 3'd3,
    CLASS_FLUSH  = 3'd4,
    CLASS_ATOMIC = 3'd5
  } vcache_op_class_e;

endpackage

/* logic/vcache_cfg.svh */
`ifndef VCACHE_CFG_SVH
`define VCACHE_CFG_SVH

// cache request opcode
`define VCACHE_OPCODE_WIDTH 5

// profiler counters and snapshot
`define VCACHE_CTR_WIDTH 32
`define VCACHE_TAG_WIDTH 16
`define VCACHE_NUM_STATS 12
`define VCACHE_STAT_SEL_WIDTH 4

`endif
